// ==== memory.f ====
+incdir+src
src/mem_pkg.sv
src/memory_read.sv
src/memory_write.sv
src/avalon_mem.sv
src/memory.sv
verification/memory_sva.sv
verification/memory_tb.sv

// ==== verification/memory_tb.sv ====
//------------------------------
// memory unit testbench
// avalon memory model with random stalls, byte
// reference model and table driven requests
//------------------------------

`include "mem_consts.svh"

module memory_tb;

timeunit 1ns;
timeprecision 100ps;

localparam logic [1:0]  OP_RD   = 2'd1;         // bit 0 read, bit 1 write
localparam logic [1:0]  OP_WR   = 2'd2;
localparam logic [1:0]  OP_BOTH = 2'd3;
localparam int          N_ROWS  = 11;
localparam int          TIMEOUT = 200;          // cycles per request

typedef struct packed {
    logic [1:0]     op;
    logic [31:0]    addr;
    logic [3:0]     len;
    logic [31:0]    data;
} row_t;

logic                               clk;
logic                               rst;
logic                               read_do;
mem_pkg::mem_read_req_t             read_req;
logic                               read_done;
logic [`MEM_READ_MAX_BYTES*8-1:0]   read_data;
logic                               write_do;
mem_pkg::mem_write_req_t            write_req;
logic                               write_done;
mem_pkg::mem_word_addr_t            avm_address;
logic [31:0]                        avm_writedata;
logic [3:0]                         avm_byteenable;
logic                               avm_read;
logic                               avm_write;
logic                               avm_waitrequest;
logic                               avm_readdatavalid;
logic [31:0]                        avm_readdata;

logic [31:0]    bus_mem [64];                   // bus side words
logic [7:0]     ref_mem [256];                  // same bytes, reference view
logic [31:0]    lfsr_state;
logic           stall_en;                       // random waitrequest and latency
int             rd_wait;                        // cycles left until readdatavalid
logic [5:0]     rd_addr;
row_t           stim_rows [N_ROWS];

memory memory_inst(.*);

initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
end

//------------------------------
// helpers

function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    if (s[0]) begin
        return (s >> 1) ^ 32'hA300_0000;        // taps 32 30 26 25
    end
    return s >> 1;
endfunction

task automatic take_bits(input int n, output logic [31:0] v);
    v = '0;
    for (int i = 0; i < n; i++) begin
        lfsr_state = lfsr_next(lfsr_state);
        v = {v[30:0], lfsr_state[0]};           // one step per bit
    end
endtask

task automatic stop_on_error(input string what);
    $display("%s", what);
    $display("Test failed");
    $fatal(1, "run stopped at first error");
endtask

task automatic check_value(input string name, input logic [63:0] got, input logic [63:0] exp);
    if (got !== exp) begin
        stop_on_error($sformatf("Mismatch at %0t: %s got %h expected %h", $time, name, got, exp));
    end
endtask

// bound protocol checker
always @(negedge clk) begin
    if (memory_inst.memory_sva_inst.fail_count != 0) begin
        stop_on_error("a protocol assertion on the memory unit failed");
    end
end

//------------------------------
// avalon slave model driven on the falling edge

always @(negedge clk) begin
    logic [31:0]    r;
    int             lat;
    avm_readdatavalid = 1'b0;
    if (rd_wait != 0) begin
        rd_wait = rd_wait - 1;
        if (rd_wait == 0) begin
            avm_readdatavalid = 1'b1;
            avm_readdata      = bus_mem[rd_addr];
        end
    end
    avm_waitrequest = 1'b0;
    if (stall_en) begin
        take_bits(1, r);
        avm_waitrequest = r[0];
    end
    // command seen now is accepted at the next rising edge
    if (avm_write === 1'b1 && !avm_waitrequest) begin
        for (int b = 0; b < 4; b++) begin
            if (avm_byteenable[b]) begin
                bus_mem[avm_address[5:0]][b*8 +: 8] = avm_writedata[b*8 +: 8];
            end
        end
    end
    if (avm_read === 1'b1 && !avm_waitrequest) begin
        check_value("avm_byteenable", avm_byteenable, 64'hF);     // whole word on reads
        lat = 0;
        if (stall_en) begin
            take_bits(2, r);
            lat = r[1:0];                       // 0 to 3 cycles
        end
        if (lat == 0) begin
            avm_readdatavalid = 1'b1;           // same cycle as accept
            avm_readdata      = bus_mem[avm_address[5:0]];
        end else begin
            rd_wait = lat;
            rd_addr = avm_address[5:0];
        end
    end
end

//------------------------------
// one table row with both sides waited on in one loop

task automatic run_row(input row_t row);
    logic           rd_pend;
    logic           wr_pend;
    logic [63:0]    got;
    logic [63:0]    exp;
    logic [63:0]    mask;
    int             cycles;
    rd_pend = row.op[0];
    wr_pend = row.op[1];
    got     = '0;
    exp     = '0;
    mask    = '0;
    if (wr_pend) begin                          // write lands before any read word
        for (int i = 0; i < row.len; i++) begin
            ref_mem[8'(row.addr + i)] = row.data[i*8 +: 8];
        end
    end
    for (int i = 0; i < row.len; i++) begin
        exp[i*8 +: 8]  = ref_mem[8'(row.addr + i)];
        mask[i*8 +: 8] = 8'hFF;
    end
    @(negedge clk);
    read_req.addr  = row.addr;
    read_req.len   = row.len;
    write_req.addr = row.addr;
    write_req.len  = row.len[2:0];
    write_req.data = row.data;
    read_do        = rd_pend;
    write_do       = wr_pend;
    cycles         = 0;
    while (rd_pend || wr_pend || read_do || write_do) begin
        @(negedge clk);
        cycles++;
        if (!wr_pend) begin
            write_do = 1'b0;                    // held through the done cycle
        end
        if (!rd_pend) begin
            read_do = 1'b0;
        end
        if (wr_pend && write_done) begin
            wr_pend = 1'b0;
        end
        if (rd_pend && read_done) begin
            got     = read_data;
            rd_pend = 1'b0;
        end
        if (cycles > TIMEOUT) begin
            stop_on_error($sformatf("done pulse never came for request at address %h", row.addr));
        end
    end
    if (row.op[0]) begin
        check_value("read_data", got & mask, exp);
    end
endtask

//------------------------------

initial begin
    logic [31:0] v;
    rst               = 1'b1;
    read_do           = 1'b0;
    read_req          = '0;
    write_do          = 1'b0;
    write_req         = '0;
    avm_waitrequest   = 1'b0;
    avm_readdatavalid = 1'b0;
    avm_readdata      = '0;
    stall_en          = 1'b0;
    rd_wait           = 0;
    rd_addr           = '0;
    lfsr_state        = 32'd46353;
    for (int w = 0; w < 64; w++) begin
        take_bits(32, v);
        bus_mem[w] = v;
        for (int b = 0; b < 4; b++) begin
            ref_mem[w*4 + b] = v[b*8 +: 8];
        end
    end

    stim_rows[0]  = '{OP_WR,   32'h0000_0010, 4'd4, 32'hDEAD_BEEF};   // aligned word
    stim_rows[1]  = '{OP_RD,   32'h0000_0010, 4'd4, 32'h0};
    stim_rows[2]  = '{OP_WR,   32'h0000_0023, 4'd4, 32'h4433_2211};   // spans two words
    stim_rows[3]  = '{OP_RD,   32'h0000_0021, 4'd8, 32'h0};           // neighbours unchanged
    stim_rows[4]  = '{OP_RD,   32'h0000_0033, 4'd8, 32'h0};           // three words
    stim_rows[5]  = '{OP_RD,   32'h0000_0042, 4'd1, 32'h0};
    stim_rows[6]  = '{OP_WR,   32'h0000_004E, 4'd2, 32'h0000_A5C3};
    stim_rows[7]  = '{OP_BOTH, 32'h0000_004D, 4'd4, 32'h0BAD_F00D};   // write wins
    stim_rows[8]  = '{OP_RD,   32'h0000_00FD, 4'd8, 32'h0};           // wraps model
    stim_rows[9]  = '{OP_WR,   32'h0000_1001, 4'd3, 32'h0066_5544};
    stim_rows[10] = '{OP_RD,   32'h0000_1000, 4'd5, 32'h0};

    repeat (2) @(negedge clk);
    rst = 1'b0;
    @(negedge clk);
    check_value("avm_read", avm_read, 1'b0);
    check_value("avm_write", avm_write, 1'b0);
    check_value("read_done", read_done, 1'b0);
    check_value("write_done", write_done, 1'b0);

    // first pass without stalls, second with random back-pressure
    for (int pass = 0; pass < 2; pass++) begin
        @(posedge clk);
        stall_en = (pass == 1);
        for (int r = 0; r < N_ROWS; r++) begin
            run_row(stim_rows[r]);
        end
    end

    if (memory_inst.memory_sva_inst.fail_count != 0) begin
        stop_on_error("a protocol assertion on the memory unit failed");
    end else begin
        $display("Test completed successfully");
        $finish;
    end
end

endmodule

// ==== verification/memory_sva.sv ====
//------------------------------
// memory unit assertions
// avalon command rules and done pulse protocol
//------------------------------

`include "mem_consts.svh"

module memory_sva(
    input  logic                            clk,
    input  logic                            rst,
    input  logic                            read_do,
    input  logic                            read_done,
    input  logic                            write_do,
    input  logic                            write_done,
    input  logic                            rd_word_do,
    input  logic                            wr_word_do,
    input  logic                            avm_read,
    input  logic                            avm_write,
    input  logic                            avm_waitrequest,
    input  mem_pkg::mem_word_addr_t         avm_address,
    input  logic [`MEM_WORD_BYTES*8-1:0]    avm_writedata,
    input  logic [`MEM_WORD_BYTES-1:0]      avm_byteenable
);

timeunit 1ns;
timeprecision 100ps;

int fail_count = 0;                                 // assertion failures so far

// one command at a time
cmd_exclusive: assert property (@(posedge clk) disable iff (rst)
    !(avm_read && avm_write))
    else begin
        $error("avm_read and avm_write high together");
        fail_count++;
    end

// held command may not move while stalled
cmd_stable: assert property (@(posedge clk) disable iff (rst)
    (avm_read || avm_write) && avm_waitrequest |=>
        $stable(avm_read) && $stable(avm_write) && $stable(avm_address) &&
        $stable(avm_writedata) && $stable(avm_byteenable))
    else begin
        $error("avalon command changed under waitrequest");
        fail_count++;
    end

rd_done_held: assert property (@(posedge clk) disable iff (rst)
    read_done |-> read_do)
    else begin
        $error("read_done without read_do");
        fail_count++;
    end

wr_done_held: assert property (@(posedge clk) disable iff (rst)
    write_done |-> write_do)
    else begin
        $error("write_done without write_do");
        fail_count++;
    end

// everything quiet right after reset
reset_idle: assert property (@(posedge clk)
    rst |=> !avm_read && !avm_write && !read_done && !write_done &&
        !rd_word_do && !wr_word_do)
    else begin
        $error("outputs not idle after reset");
        fail_count++;
    end

endmodule

bind memory memory_sva memory_sva_inst(
    .clk             (clk),
    .rst             (rst),
    .read_do         (read_do),
    .read_done       (read_done),
    .write_do        (write_do),
    .write_done      (write_done),
    .rd_word_do      (rd_word_do),
    .wr_word_do      (wr_word_do),
    .avm_read        (avm_read),
    .avm_write       (avm_write),
    .avm_waitrequest (avm_waitrequest),
    .avm_address     (avm_address),
    .avm_writedata   (avm_writedata),
    .avm_byteenable  (avm_byteenable)
);

// ==== src/memory.sv ====
//------------------------------
// data memory unit, top level
// read and write engines sharing one avalon master
//------------------------------

`include "mem_consts.svh"

module memory(
    input  logic                                clk,
    input  logic                                rst,

    // read request
    input  logic                                read_do,
    input  mem_pkg::mem_read_req_t              read_req,
    output logic                                read_done,
    output logic [`MEM_READ_MAX_BYTES*8-1:0]    read_data,

    // write request
    input  logic                                write_do,
    input  mem_pkg::mem_write_req_t             write_req,
    output logic                                write_done,

    // avalon master
    output mem_pkg::mem_word_addr_t             avm_address,
    output logic [`MEM_WORD_BYTES*8-1:0]        avm_writedata,
    output logic [`MEM_WORD_BYTES-1:0]          avm_byteenable,
    output logic                                avm_read,
    output logic                                avm_write,
    input  logic                                avm_waitrequest,
    input  logic                                avm_readdatavalid,
    input  logic [`MEM_WORD_BYTES*8-1:0]        avm_readdata
);

//------------------------------

logic                               rd_word_do;
logic                               rd_word_done;
mem_pkg::mem_word_addr_t            rd_word_addr;
logic [`MEM_WORD_BYTES*8-1:0]       rd_word_data;

logic                               wr_word_do;
logic                               wr_word_done;
mem_pkg::mem_wr_word_t              wr_word;

//------------------------------

memory_read memory_read_inst(
    .clk            (clk),
    .rst            (rst),
    .read_do        (read_do),          // in
    .read_req       (read_req),         // in
    .read_done      (read_done),        // out, one cycle
    .read_data      (read_data),        // out [63:0]
    .rd_word_do     (rd_word_do),       // out
    .rd_word_addr   (rd_word_addr),     // out
    .rd_word_done   (rd_word_done),     // in
    .rd_word_data   (rd_word_data)      // in [31:0]
);

memory_write memory_write_inst(
    .clk            (clk),
    .rst            (rst),
    .write_do       (write_do),         // in
    .write_req      (write_req),        // in
    .write_done     (write_done),       // out, one cycle
    .wr_word_do     (wr_word_do),       // out
    .wr_word        (wr_word),          // out addr, data, be
    .wr_word_done   (wr_word_done)      // in
);

avalon_mem avalon_mem_inst(
    .clk                (clk),
    .rst                (rst),
    .rd_word_do         (rd_word_do),
    .rd_word_addr       (rd_word_addr),
    .rd_word_done       (rd_word_done),
    .rd_word_data       (rd_word_data),
    .wr_word_do         (wr_word_do),
    .wr_word            (wr_word),
    .wr_word_done       (wr_word_done),
    .avm_address        (avm_address),
    .avm_writedata      (avm_writedata),
    .avm_byteenable     (avm_byteenable),
    .avm_read           (avm_read),
    .avm_write          (avm_write),
    .avm_waitrequest    (avm_waitrequest),
    .avm_readdatavalid  (avm_readdatavalid),
    .avm_readdata       (avm_readdata)
);

endmodule

// ==== src/avalon_mem.sv ====
//------------------------------
// avalon master
// one word access at a time, writes win
//------------------------------

`include "mem_consts.svh"

module avalon_mem(
    input  logic                            clk,
    input  logic                            rst,

    input  logic                            rd_word_do,
    input  mem_pkg::mem_word_addr_t         rd_word_addr,
    output logic                            rd_word_done,
    output logic [`MEM_WORD_BYTES*8-1:0]    rd_word_data,

    input  logic                            wr_word_do,
    input  mem_pkg::mem_wr_word_t           wr_word,
    output logic                            wr_word_done,

    output mem_pkg::mem_word_addr_t         avm_address,
    output logic [`MEM_WORD_BYTES*8-1:0]    avm_writedata,
    output logic [`MEM_WORD_BYTES-1:0]      avm_byteenable,
    output logic                            avm_read,
    output logic                            avm_write,
    input  logic                            avm_waitrequest,
    input  logic                            avm_readdatavalid,
    input  logic [`MEM_WORD_BYTES*8-1:0]    avm_readdata
);

typedef enum logic [1:0] {
    ST_IDLE,
    ST_WR_CMD,          // avm_write held through waitrequest
    ST_RD_CMD,          // avm_read held through waitrequest
    ST_RD_WAIT          // read accepted, waiting for readdatavalid
} state_t;

state_t state;
logic   grant_ok;

// engines still show the finished word during a done pulse
assign grant_ok = (state == ST_IDLE) && !rd_word_done && !wr_word_done;

//------------------------------

always_ff @(posedge clk) begin
    if (rst) begin
        state        <= ST_IDLE;
        avm_read     <= 1'b0;
        avm_write    <= 1'b0;
        rd_word_done <= 1'b0;
        wr_word_done <= 1'b0;
    end else begin
        rd_word_done <= 1'b0;
        wr_word_done <= 1'b0;
        case (state)
            ST_IDLE: begin
                if (grant_ok && wr_word_do) begin       // write first
                    avm_write <= 1'b1;
                    state     <= ST_WR_CMD;
                end else if (grant_ok && rd_word_do) begin
                    avm_read  <= 1'b1;
                    state     <= ST_RD_CMD;
                end
            end
            ST_WR_CMD: begin
                if (!avm_waitrequest) begin
                    avm_write    <= 1'b0;
                    wr_word_done <= 1'b1;
                    state        <= ST_IDLE;
                end
            end
            ST_RD_CMD: begin
                if (!avm_waitrequest) begin
                    avm_read <= 1'b0;
                    state    <= avm_readdatavalid ? ST_IDLE : ST_RD_WAIT;
                    rd_word_done <= avm_readdatavalid;
                end
            end
            default: begin                              // ST_RD_WAIT
                if (avm_readdatavalid) begin
                    rd_word_done <= 1'b1;
                    state        <= ST_IDLE;
                end
            end
        endcase
    end
end

// command payload, loaded only when a command starts
always_ff @(posedge clk) begin
    if (grant_ok && wr_word_do) begin
        avm_address    <= wr_word.addr;
        avm_writedata  <= wr_word.data;
        avm_byteenable <= wr_word.be;
    end else if (grant_ok && rd_word_do) begin
        avm_address    <= rd_word_addr;
        avm_byteenable <= '1;                           // whole word on reads
    end
    if (avm_readdatavalid) begin
        rd_word_data <= avm_readdata;
    end
end

endmodule

// ==== src/memory_write.sv ====
//------------------------------
// write engine
// one byte write becomes one or two byte enabled
// word writes, lower word first
//------------------------------

`include "mem_consts.svh"

module memory_write(
    input  logic                        clk,
    input  logic                        rst,

    input  logic                        write_do,
    input  mem_pkg::mem_write_req_t     write_req,
    output logic                        write_done,

    output logic                        wr_word_do,
    output mem_pkg::mem_wr_word_t       wr_word,
    input  logic                        wr_word_done
);

//------------------------------

logic                                   busy;
logic                                   upper;          // second word in flight
logic                                   start;
logic                                   last_word;
logic [1:0]                             offset;
logic [`MEM_WRITE_MAX_BYTES-1:0]        len_mask;       // one bit per valid byte
mem_pkg::mem_word_addr_t                base_addr;
logic [2*`MEM_WORD_BYTES*8-1:0]         span_data;      // two word span
logic [2*`MEM_WORD_BYTES-1:0]           span_be;

//------------------------------

assign start     = write_do && !busy && !write_done;
assign offset    = write_req.addr[1:0];
assign last_word = upper || (span_be[2*`MEM_WORD_BYTES-1:`MEM_WORD_BYTES] == '0);

always_comb begin
    for (int i = 0; i < `MEM_WRITE_MAX_BYTES; i++) begin
        len_mask[i] = (i < write_req.len);
    end
end

assign wr_word_do = busy;

// word selected by phase
always_comb begin
    wr_word.addr = base_addr + mem_pkg::mem_word_addr_t'(upper);
    if (upper) begin
        wr_word.data = span_data[2*`MEM_WORD_BYTES*8-1:`MEM_WORD_BYTES*8];
        wr_word.be   = span_be[2*`MEM_WORD_BYTES-1:`MEM_WORD_BYTES];
    end else begin
        wr_word.data = span_data[`MEM_WORD_BYTES*8-1:0];
        wr_word.be   = span_be[`MEM_WORD_BYTES-1:0];
    end
end

// control
always_ff @(posedge clk) begin
    if (rst) begin
        busy       <= 1'b0;
        upper      <= 1'b0;
        write_done <= 1'b0;
    end else begin
        write_done <= 1'b0;                             // pulse
        if (start) begin
            busy  <= 1'b1;
            upper <= 1'b0;
        end else if (busy && wr_word_done) begin
            if (last_word) begin
                busy       <= 1'b0;
                upper      <= 1'b0;
                write_done <= 1'b1;                     // cycle after last word
            end else begin
                upper <= 1'b1;                          // enables spill into next word
            end
        end
    end
end

// shifted data and enables
always_ff @(posedge clk) begin
    if (start) begin
        base_addr <= write_req.addr[`MEM_ADDR_W-1:2];
        span_data <= {{`MEM_WORD_BYTES*8{1'b0}}, write_req.data} << {offset, 3'b000};
        span_be   <= {{`MEM_WORD_BYTES{1'b0}}, len_mask} << offset;
    end
end

endmodule

// ==== src/memory_read.sv ====
//------------------------------
// read engine
// splits a byte read into 1 to 3 word reads, then
// picks 8 bytes from the offset for the pipeline
//------------------------------

`include "mem_consts.svh"

module memory_read(
    input  logic                                clk,
    input  logic                                rst,

    input  logic                                read_do,
    input  mem_pkg::mem_read_req_t              read_req,
    output logic                                read_done,
    output logic [`MEM_READ_MAX_BYTES*8-1:0]    read_data,

    output logic                                rd_word_do,
    output mem_pkg::mem_word_addr_t             rd_word_addr,
    input  logic                                rd_word_done,
    input  logic [`MEM_WORD_BYTES*8-1:0]        rd_word_data
);

//------------------------------

logic                               busy;           // words still owed
logic                               start;
logic                               last_word;
logic [1:0]                         word_idx;       // word being fetched
logic [1:0]                         last_idx;       // word count minus one
logic [1:0]                         offset;         // byte offset in first word
logic [3:0]                         span_bytes;     // offset + len + 3, max 14
mem_pkg::mem_word_addr_t            base_addr;
mem_pkg::mem_read_window_t          window;
mem_pkg::mem_read_window_t          window_next;
logic [`MEM_READ_MAX_BYTES*8-1:0]   extract;

//------------------------------

assign start        = read_do && !busy && !read_done;   // held read_do is not a new read
assign span_bytes   = {2'b00, read_req.addr[1:0]} + read_req.len + 4'd3;
assign last_word    = (word_idx == last_idx);

assign rd_word_do   = busy;
assign rd_word_addr = base_addr + mem_pkg::mem_word_addr_t'(word_idx);

// window as it will be after this cycle, so the last word is seen at once
always_comb begin
    window_next = window;
    if (rd_word_done) begin
        window_next.words[word_idx] = rd_word_data;     // word view
    end
    for (int i = 0; i < `MEM_READ_MAX_BYTES; i++) begin
        extract[i*8 +: 8] = window_next.bytes[offset + i];  // byte view
    end
end

// control
always_ff @(posedge clk) begin
    if (rst) begin
        busy      <= 1'b0;
        read_done <= 1'b0;
        word_idx  <= 2'd0;
    end else begin
        read_done <= 1'b0;                              // pulse
        if (start) begin
            busy     <= 1'b1;
            word_idx <= 2'd0;
        end else if (busy && rd_word_done) begin
            word_idx <= word_idx + 2'd1;                // ascending words
            if (last_word) begin
                busy      <= 1'b0;
                read_done <= 1'b1;                      // cycle after last word
            end
        end
    end
end

// request capture and data
always_ff @(posedge clk) begin
    if (start) begin
        base_addr <= read_req.addr[`MEM_ADDR_W-1:2];
        offset    <= read_req.addr[1:0];
        last_idx  <= span_bytes[3:2] - 2'd1;            // 1 to 3 words
    end
    window <= window_next;
    if (busy && rd_word_done && last_word) begin
        read_data <= extract;                           // held until next read_done
    end
end

endmodule

// ==== src/mem_pkg.sv ====
//------------------------------
// memory unit shared types
// request structs, bus word struct and read window
//------------------------------

`include "mem_consts.svh"

package mem_pkg;

typedef logic [`MEM_ADDR_W-3:0] mem_word_addr_t;           // byte address without [1:0]

typedef struct packed {
    logic [`MEM_ADDR_W-1:0]             addr;               // byte address
    logic [3:0]                         len;                // 1 to 8 bytes
} mem_read_req_t;

typedef struct packed {
    logic [`MEM_ADDR_W-1:0]             addr;               // byte address
    logic [2:0]                         len;                // 1 to 4 bytes
    logic [`MEM_WRITE_MAX_BYTES*8-1:0]  data;               // first byte in low bits
} mem_write_req_t;

typedef struct packed {
    mem_word_addr_t                     addr;
    logic [`MEM_WORD_BYTES*8-1:0]       data;
    logic [`MEM_WORD_BYTES-1:0]         be;                 // per byte enables
} mem_wr_word_t;

// same 96 bits, filled per word, read out per byte
typedef union packed {
    logic [`MEM_READ_MAX_WORDS-1:0][`MEM_WORD_BYTES*8-1:0]   words;
    logic [`MEM_READ_MAX_WORDS*`MEM_WORD_BYTES-1:0][7:0]     bytes;
} mem_read_window_t;

endpackage

// ==== src/mem_consts.svh ====
//------------------------------
// memory unit constants
// sizes of addresses, bus words and pipeline requests
//------------------------------

`ifndef MEM_CONSTS_SVH
`define MEM_CONSTS_SVH

// bus side
`define MEM_ADDR_W              32  // byte address width
`define MEM_WORD_BYTES          4   // bytes per avalon word

// pipeline side
`define MEM_READ_MAX_BYTES      8   // longest read request
`define MEM_READ_MAX_WORDS      3   // worst case words touched by a read
`define MEM_WRITE_MAX_BYTES     4   // longest write request

`endif
